// File: source/rp_cfg_pkg.sv
/* Data path widths and calibration formats. Raw ADC words carry 14 useful bits
   above 2 reserved low bits, and gain is signed Q2.14 */
`default_nettype none

package rp_cfg_pkg;

  // Channel count for ADC and DAC alike
  localparam int unsigned CHN = 2;

  // Raw pin word and useful sample width
  localparam int unsigned ADW = 16;
  localparam int unsigned SMW = 14;

  // Fractional bits of the gain word
  localparam int unsigned GAIN_FRAC = 14;

  // Raw ADC pin word, low 2 bits reserved
  typedef logic [ADW-1:0] adc_raw_t;

  // Two's complement sample, ADC and generator payload
  typedef logic signed [SMW-1:0] sample_t;

  // Offset-binary DAC code
  typedef logic [SMW-1:0] dac_code_t;

  // Calibration words
  typedef logic signed [16-1:0] gain_t;
  typedef logic signed [SMW-1:0] offs_t;

endpackage : rp_cfg_pkg

`default_nettype wire

// File: source/acq_pkg.sv
/* Acquisition controller types. The post-trigger count must be at least 1 */
`default_nettype none

package acq_pkg;

  // Time stamp and post-trigger counter widths
  localparam int unsigned CTS_W = 32;
  localparam int unsigned POST_W = 16;

  // Acquisition states
  typedef enum logic [1:0] {
    ACQ_IDLE      = 2'd0,
    ACQ_ARMED     = 2'd1,
    ACQ_TRIGGERED = 2'd2
  } acq_state_t;

  // Free-running time stamp, wraps silently
  typedef logic [CTS_W-1:0] cts_t;

  // Number of samples recorded after the trigger
  typedef logic [POST_W-1:0] post_t;

endpackage : acq_pkg

`default_nettype wire

// File: source/adc_frontend.sv
/* One ADC channel input register with sign conversion and loopback select.
   Output is always valid, the loopback mux after the register is combinational */
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  wire                  adc_clk,
  input  wire                  top_rst,
  // Raw pins and loopback source
  input  rp_cfg_pkg::adc_raw_t adc_raw_i,
  input  wire                  loop_i,
  input  rp_cfg_pkg::sample_t  dac_smp_i,
  // Toward ADC calibration
  output rp_cfg_pkg::sample_t  adc_smp_o
);

  import rp_cfg_pkg::*;

  // Registered pin sample
  sample_t adc_reg;

  //////////////////////
  // Pin register
  //////////////////////

  // Drop reserved low bits
  // Keep MSB, invert the rest for two's complement
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_reg <= '0;
    end else begin
      adc_reg <= {adc_raw_i[ADW-1], ~adc_raw_i[ADW-2:ADW-SMW]};
    end
  end

  //////////////////////
  // Loopback mux
  //////////////////////

  // DAC-side sample replaces pin data when looped
  assign adc_smp_o = loop_i ? dac_smp_i : adc_reg;

endmodule : adc_frontend

`default_nettype wire

// File: source/linear_calib.sv
/* Gain and offset calibration, 2 cycles latency, one sample per cycle.
   DTI and DTO must be signed, and the result saturates to the DTO range */
`timescale 1ns/1ps
`default_nettype none

module linear_calib #(
  parameter type DTI = rp_cfg_pkg::sample_t,
  parameter type DTO = rp_cfg_pkg::sample_t
)(
  input  wire                 adc_clk,
  input  wire                 top_rst,
  // Sample stream
  input  DTI                  dat_i,
  output DTO                  dat_o,
  // Calibration words
  input  rp_cfg_pkg::gain_t   mul_i,
  input  rp_cfg_pkg::offs_t   sum_i
);

  import rp_cfg_pkg::*;

  // Widths derived from payload types
  localparam int unsigned IW = $bits(DTI);
  localparam int unsigned OW = $bits(DTO);
  localparam int unsigned MW = IW + $bits(gain_t);
  // Shifted product plus one guard bit for the offset add
  localparam int unsigned SW = MW - GAIN_FRAC + 1;

  // Output range limits, sign extended to the sum width
  localparam logic signed [SW-1:0] OMAX = SW'((2 ** (OW - 1)) - 1);
  // Bitwise inverse of max is the most negative code
  localparam logic signed [SW-1:0] OMIN = ~OMAX;

  // Stage 1 product
  logic signed [MW-1:0] mul_q;

  // Stage 2 arithmetic
  logic signed [MW-GAIN_FRAC-1:0] mul_sh;
  logic signed [SW-1:0]           sum_w;

  //////////////////////
  // Stage 1
  //////////////////////

  // Full-width signed product
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      mul_q <= '0;
    end else begin
      mul_q <= MW'(dat_i) * MW'(mul_i);
    end
  end

  //////////////////////
  // Stage 2
  //////////////////////

  // Drop fractional bits, then add offset
  assign mul_sh = mul_q[MW-1:GAIN_FRAC];
  assign sum_w  = SW'(mul_sh) + SW'(sum_i);

  // Clamp to output range
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else if (sum_w > OMAX) begin
      dat_o <= OMAX[OW-1:0];
    end else if (sum_w < OMIN) begin
      dat_o <= OMIN[OW-1:0];
    end else begin
      dat_o <= sum_w[OW-1:0];
    end
  end

endmodule : linear_calib

`default_nettype wire

// File: source/dac_path.sv
/* One DAC channel, calibration then an output register, 3 cycles in total.
   The calibrated sample before the output register is given for loopback */
`timescale 1ns/1ps
`default_nettype none

module dac_path (
  input  wire                   adc_clk,
  input  wire                   top_rst,
  // Generator sample and calibration
  input  rp_cfg_pkg::sample_t   gen_i,
  input  rp_cfg_pkg::gain_t     mul_i,
  input  rp_cfg_pkg::offs_t     sum_i,
  // Loopback tap and DAC pins
  output rp_cfg_pkg::sample_t   dac_smp_o,
  output rp_cfg_pkg::dac_code_t dac_dat_o
);

  import rp_cfg_pkg::*;

  // Generator calibration, 2 cycles
  linear_calib #(
    .DTI (sample_t),
    .DTO (sample_t)
  ) calib_dac (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (gen_i),
    .dat_o   (dac_smp_o),
    .mul_i   (mul_i),
    .sum_i   (sum_i)
  );

  // Offset-binary output register
  // MSB kept, lower bits inverted
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_dat_o <= '0;
    end else begin
      dac_dat_o <= {dac_smp_o[SMW-1], ~dac_smp_o[SMW-2:0]};
    end
  end

endmodule : dac_path

`default_nettype wire

// File: source/acq_fsm.sv
/* Acquisition control, armed by start and ended by stop or the post-trigger
   count. Stop wins over a trigger seen in the same cycle */
`timescale 1ns/1ps
`default_nettype none

module acq_fsm (
  input  wire                 adc_clk,
  input  wire                 top_rst,
  // Software controls
  input  wire                 start_i,
  input  wire                 stop_i,
  input  wire                 swo_i,
  // Level trigger on channel 0
  input  rp_cfg_pkg::sample_t lvl_i,
  input  rp_cfg_pkg::sample_t smp_i,
  // Final triggered cycle from the timer
  input  wire                 post_last_i,
  // Trigger toward the timer
  output logic                trg_o,
  // Interrupts and valid
  output logic                irq_trg_o,
  output logic                irq_stp_o,
  output logic                vld_o
);

  import rp_cfg_pkg::*;
  import acq_pkg::*;

  acq_state_t state;
  acq_state_t state_nxt;

  // Previous channel 0 sample
  sample_t smp_prv;

  logic lvl_cross;
  logic stp_evt;

  //////////////////////
  // Trigger detection
  //////////////////////

  // Rising crossing, below before and at or above now
  assign lvl_cross = (smp_prv < lvl_i) && (smp_i >= lvl_i);

  assign trg_o = (state == ACQ_ARMED) && !stop_i && (swo_i || lvl_cross);

  // Any way back to idle
  assign stp_evt = ((state != ACQ_IDLE) && stop_i)
                || ((state == ACQ_TRIGGERED) && post_last_i);

  //////////////////////
  // State machine
  //////////////////////

  always_comb begin
    state_nxt = state;
    unique case (state)
      ACQ_IDLE: begin
        if (start_i) state_nxt = ACQ_ARMED;
      end
      ACQ_ARMED: begin
        if (stop_i) state_nxt = ACQ_IDLE;
        else if (trg_o) state_nxt = ACQ_TRIGGERED;
      end
      ACQ_TRIGGERED: begin
        if (stp_evt) state_nxt = ACQ_IDLE;
      end
      default: state_nxt = ACQ_IDLE;
    endcase
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state     <= ACQ_IDLE;
      smp_prv   <= '0;
      irq_trg_o <= 1'b0;
      irq_stp_o <= 1'b0;
    end else begin
      state     <= state_nxt;
      smp_prv   <= smp_i;
      // Pulses line up with the first cycle of the new state
      irq_trg_o <= trg_o;
      irq_stp_o <= stp_evt;
    end
  end

  // Samples valid while armed or triggered
  assign vld_o = (state != ACQ_IDLE);

endmodule : acq_fsm

`default_nettype wire

// File: source/acq_timer.sv
/* Free-running time stamp and post-trigger down counter. The time stamp is 0
   in the first cycle after reset release, a post count of 0 never ends */
`timescale 1ns/1ps
`default_nettype none

module acq_timer (
  input  wire            adc_clk,
  input  wire            top_rst,
  // Trigger from the FSM and post-trigger length
  input  wire            trg_i,
  input  acq_pkg::post_t post_i,
  // Captured time stamp and end marker
  output acq_pkg::cts_t  trg_ts_o,
  output logic           post_last_o
);

  import acq_pkg::*;

  cts_t  cts;
  post_t post_cnt;

  // Time stamp counter, plus capture at the trigger edge
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cts      <= '0;
      trg_ts_o <= '0;
    end else begin
      cts <= cts + cts_t'(1);
      if (trg_i) trg_ts_o <= cts;
    end
  end

  // Down counter
  // Holds N in the first triggered cycle, 1 in the last
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      post_cnt <= '0;
    end else if (trg_i) begin
      post_cnt <= post_i;
    end else if (post_cnt != '0) begin
      post_cnt <= post_cnt - post_t'(1);
    end
  end

  assign post_last_o = (post_cnt == post_t'(1));

endmodule : acq_timer

`default_nettype wire

// File: source/rp_acq_top.sv
/* Two ADC and two DAC channels with calibration and one acquisition controller.
   Single clock domain, no back-pressure, level trigger on channel 0 only */
`timescale 1ns/1ps
`default_nettype none

module rp_acq_top (
  input  wire                                          adc_clk,
  input  wire                                          top_rst,
  // ADC pins and generator samples
  input  rp_cfg_pkg::adc_raw_t  [rp_cfg_pkg::CHN-1:0]  adc_dat_i,
  input  rp_cfg_pkg::sample_t   [rp_cfg_pkg::CHN-1:0]  gen_dat_i,
  input  wire                   [rp_cfg_pkg::CHN-1:0]  mux_loop_i,
  // Calibration
  input  rp_cfg_pkg::gain_t     [rp_cfg_pkg::CHN-1:0]  adc_mul_i,
  input  rp_cfg_pkg::offs_t     [rp_cfg_pkg::CHN-1:0]  adc_sum_i,
  input  rp_cfg_pkg::gain_t     [rp_cfg_pkg::CHN-1:0]  dac_mul_i,
  input  rp_cfg_pkg::offs_t     [rp_cfg_pkg::CHN-1:0]  dac_sum_i,
  // Acquisition control
  input  wire                                          acq_start_i,
  input  wire                                          acq_stop_i,
  input  wire                                          trg_swo_i,
  input  rp_cfg_pkg::sample_t                          trg_lvl_i,
  input  acq_pkg::post_t                               acq_post_i,
  // Outputs
  output rp_cfg_pkg::dac_code_t [rp_cfg_pkg::CHN-1:0]  dac_dat_o,
  output rp_cfg_pkg::sample_t   [rp_cfg_pkg::CHN-1:0]  acq_dat_o,
  output logic                                         acq_vld_o,
  output acq_pkg::cts_t                                trg_ts_o,
  output logic                                         irq_trg_o,
  output logic                                         irq_stp_o
);

  import rp_cfg_pkg::*;

  // Trigger and end of post-trigger count
  logic trg;
  logic post_last;

  //////////////////////
  // Analog channels
  //////////////////////

  for (genvar i = 0; i < CHN; i++) begin : g_chn
    // Frontend output and loopback tap
    sample_t adc_smp;
    sample_t dac_smp;

    adc_frontend frontend (
      .adc_clk (adc_clk), .top_rst (top_rst), .adc_raw_i (adc_dat_i[i]),
      .loop_i (mux_loop_i[i]), .dac_smp_i (dac_smp), .adc_smp_o (adc_smp)
    );

    linear_calib #(.DTI (sample_t), .DTO (sample_t)) calib_adc (
      .adc_clk (adc_clk), .top_rst (top_rst), .dat_i (adc_smp),
      .dat_o (acq_dat_o[i]), .mul_i (adc_mul_i[i]), .sum_i (adc_sum_i[i])
    );

    dac_path dac (
      .adc_clk (adc_clk), .top_rst (top_rst), .gen_i (gen_dat_i[i]),
      .mul_i (dac_mul_i[i]), .sum_i (dac_sum_i[i]),
      .dac_smp_o (dac_smp), .dac_dat_o (dac_dat_o[i])
    );
  end : g_chn

  //////////////////////
  // Acquisition
  //////////////////////

  // Level trigger watches calibrated channel 0
  acq_fsm fsm (
    .adc_clk (adc_clk), .top_rst (top_rst), .start_i (acq_start_i),
    .stop_i (acq_stop_i), .swo_i (trg_swo_i), .lvl_i (trg_lvl_i),
    .smp_i (acq_dat_o[0]), .post_last_i (post_last), .trg_o (trg),
    .irq_trg_o (irq_trg_o), .irq_stp_o (irq_stp_o), .vld_o (acq_vld_o)
  );

  acq_timer timer (
    .adc_clk (adc_clk), .top_rst (top_rst), .trg_i (trg),
    .post_i (acq_post_i), .trg_ts_o (trg_ts_o), .post_last_o (post_last)
  );

endmodule : rp_acq_top

`default_nettype wire

// File: tests/acq_assert.sv
/* Concurrent checks bound into every acq_fsm instance and disabled during reset */
`timescale 1ns/1ps
`default_nettype none

module acq_assert (
  input wire                 adc_clk,
  input wire                 top_rst,
  input acq_pkg::acq_state_t state_i,
  input wire                 post_last_i,
  input wire                 irq_trg_i,
  input wire                 irq_stp_i,
  input wire                 vld_i
);

  import acq_pkg::*;

  // Trigger interrupt is a single-cycle pulse
  irq_trg_pulse: assert property (
    @(posedge adc_clk) disable iff (top_rst) irq_trg_i |=> !irq_trg_i
  ) else $error("irq_trg_o high for more than one cycle");

  // Stop pulse follows the last triggered cycle
  irq_stp_after_post: assert property (
    @(posedge adc_clk) disable iff (top_rst)
      (state_i == ACQ_TRIGGERED && post_last_i) |=> irq_stp_i
  ) else $error("irq_stp_o did not follow the last post-trigger cycle");

  // Stop pulse marks the first idle cycle with nothing valid
  vld_low_idle: assert property (
    @(posedge adc_clk) disable iff (top_rst) irq_stp_i |-> !vld_i
  ) else $error("vld_o high in the first idle cycle");

endmodule : acq_assert

bind acq_fsm acq_assert fsm_assert (
  .adc_clk (adc_clk), .top_rst (top_rst), .state_i (state), .post_last_i (post_last_i),
  .irq_trg_i (irq_trg_o), .irq_stp_i (irq_stp_o), .vld_i (vld_o)
);

`default_nettype wire

// File: tests/tb_top.sv
/* Directed testbench for the ADC and DAC data path and the acquisition controller.
   Inputs change on the falling edge and outputs are sampled there */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import rp_cfg_pkg::*;
  import acq_pkg::*;

  // Tests take about 300 cycles and the limit leaves a wide margin
  localparam int TIMEOUT_CYC = 2000;
  localparam int STREAM_LEN  = 48;
  localparam longint SMP_MAX = 2 ** (SMW - 1) - 1;
  localparam longint SMP_MIN = -SMP_MAX - 1;
  // Q2.14 gain words
  localparam gain_t GAIN_ONE = 16'sh4000;
  localparam gain_t GAIN_TWO = 16'sh7fff;  // Largest Q2.14 gain just under 2.0

  logic                  adc_clk;
  logic                  top_rst;
  adc_raw_t  [CHN-1:0]   adc_dat;
  sample_t   [CHN-1:0]   gen_dat;
  logic      [CHN-1:0]   mux_loop;
  gain_t     [CHN-1:0]   adc_mul;
  offs_t     [CHN-1:0]   adc_sum;
  gain_t     [CHN-1:0]   dac_mul;
  offs_t     [CHN-1:0]   dac_sum;
  logic                  acq_start;
  logic                  acq_stop;
  logic                  trg_swo;
  sample_t               trg_lvl;
  post_t                 acq_post;
  dac_code_t [CHN-1:0]   dac_dat;
  sample_t   [CHN-1:0]   acq_dat;
  logic                  acq_vld;
  cts_t                  trg_ts;
  logic                  irq_trg;
  logic                  irq_stp;

  // Error counts and cycle counters
  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  int          cyc_cnt = 0;
  cts_t        edge_cnt = '0;
  logic [15:0] lfsr_q = 16'd69;

  // Expected outputs in flight
  sample_t   acq_q[CHN][$];
  dac_code_t dac_q[CHN][$];

  rp_acq_top dut (
    .adc_clk (adc_clk), .top_rst (top_rst), .adc_dat_i (adc_dat), .gen_dat_i (gen_dat),
    .mux_loop_i (mux_loop), .adc_mul_i (adc_mul), .adc_sum_i (adc_sum),
    .dac_mul_i (dac_mul), .dac_sum_i (dac_sum), .acq_start_i (acq_start),
    .acq_stop_i (acq_stop), .trg_swo_i (trg_swo), .trg_lvl_i (trg_lvl),
    .acq_post_i (acq_post), .dac_dat_o (dac_dat), .acq_dat_o (acq_dat),
    .acq_vld_o (acq_vld), .trg_ts_o (trg_ts), .irq_trg_o (irq_trg), .irq_stp_o (irq_stp)
  );

  //////////////////////
  // Clock and counters
  //////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  // Edges since reset release give the time stamp seen by the next edge
  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (!top_rst) edge_cnt <= edge_cnt + cts_t'(1);
  end

  initial begin
    wait (cyc_cnt >= TIMEOUT_CYC);
    $display("Timeout after %0d cycles, the tests did not finish", cyc_cnt);
    $display("Checks failed");
    $finish;
  end

  //////////////////////
  // Random and reference
  //////////////////////

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[30:0], next_rand_bit()};
    return r;
  endfunction

  // Pin word to sample with the MSB kept and the 13 bits below inverted
  function automatic sample_t raw_to_sample(input adc_raw_t raw);
    return {raw[15], ~raw[14:2]};
  endfunction

  // Pin word that yields a wanted sample
  function automatic adc_raw_t sample_to_raw(input sample_t s);
    return {s[13], ~s[12:0], 2'b00};
  endfunction

  // Product floored by 2^GAIN_FRAC plus offset and clamped to 14 bits
  function automatic sample_t calib_ref(input sample_t s, input gain_t g, input offs_t o);
    longint p;
    p = (longint'(s) * longint'(g)) >>> GAIN_FRAC;
    p = p + longint'(o);
    if (p > SMP_MAX) p = SMP_MAX;
    else if (p < SMP_MIN) p = SMP_MIN;
    return sample_t'(p);
  endfunction

  // Offset binary
  function automatic dac_code_t dac_code_ref(input sample_t s);
    return {s[13], ~s[12:0]};
  endfunction

  //////////////////////
  // Compare tasks
  //////////////////////

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      mismatch_cnt++;
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      mismatch_cnt++;
    end
  endtask

  task automatic check_ts(input string name, input cts_t got, input cts_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      mismatch_cnt++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    other_cnt++;
  endtask

  //////////////////////
  // Stimulus helpers
  //////////////////////

  // Random pins and generator samples each cycle with all four outputs checked
  task automatic run_stream(input int n);
    sample_t dac_s;
    int      lat;
    for (int ch = 0; ch < CHN; ch++) begin
      acq_q[ch].delete();
      dac_q[ch].delete();
    end
    for (int k = 0; k < n; k++) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < CHN; ch++) begin
        // Looped samples pass both calibrations and take one cycle more
        lat = mux_loop[ch] ? 4 : 3;
        if (acq_q[ch].size() == lat)
          check_sample($sformatf("acq_dat_o[%0d]", ch), acq_dat[ch], acq_q[ch].pop_front());
        if (dac_q[ch].size() == 3)
          check_code($sformatf("dac_dat_o[%0d]", ch), dac_dat[ch], dac_q[ch].pop_front());
        adc_dat[ch] = adc_raw_t'(rand_bits(ADW));
        gen_dat[ch] = sample_t'(rand_bits(SMW));
        dac_s = calib_ref(gen_dat[ch], dac_mul[ch], dac_sum[ch]);
        if (mux_loop[ch])
          acq_q[ch].push_back(calib_ref(dac_s, adc_mul[ch], adc_sum[ch]));
        else
          acq_q[ch].push_back(calib_ref(raw_to_sample(adc_dat[ch]), adc_mul[ch], adc_sum[ch]));
        dac_q[ch].push_back(dac_code_ref(dac_s));
      end
    end
  endtask

  // Same sample on both pins until it has settled at the output
  task automatic drive_adc_const(input sample_t s);
    for (int ch = 0; ch < CHN; ch++) adc_dat[ch] = sample_to_raw(s);
    repeat (4) @(negedge adc_clk);
  endtask

  task automatic settle_quiet();
    mux_loop = '0;
    adc_mul  = {CHN{GAIN_ONE}};
    dac_mul  = {CHN{GAIN_ONE}};
    adc_sum  = '0;
    dac_sum  = '0;
    gen_dat  = '0;
    drive_adc_const('0);
  endtask

  //////////////////////
  // Directed tests
  //////////////////////

  task automatic test_adc_unity();
    settle_quiet();
    run_stream(STREAM_LEN);
  endtask

  task automatic test_calib_sat();
    adc_mul    = {CHN{GAIN_TWO}};
    adc_sum[0] = 14'sd300;
    adc_sum[1] = -14'sd450;
    run_stream(STREAM_LEN);
    // Full scale must clamp on both sides
    drive_adc_const(sample_t'(SMP_MAX));
    check_sample("acq_dat_o[0]", acq_dat[0], sample_t'(SMP_MAX));
    check_sample("acq_dat_o[1]", acq_dat[1], sample_t'(SMP_MAX));
    drive_adc_const(sample_t'(SMP_MIN));
    check_sample("acq_dat_o[0]", acq_dat[0], sample_t'(SMP_MIN));
    check_sample("acq_dat_o[1]", acq_dat[1], sample_t'(SMP_MIN));
  endtask

  task automatic test_dac_format();
    adc_mul    = {CHN{GAIN_ONE}};
    adc_sum    = '0;
    dac_mul[0] = 16'sh2000;
    dac_mul[1] = 16'sh6000;
    dac_sum[0] = 14'sd1000;
    dac_sum[1] = -14'sd77;
    run_stream(STREAM_LEN);
  endtask

  task automatic test_loopback();
    mux_loop   = 2'b10;
    adc_mul[1] = 16'sh5000;
    adc_sum[1] = 14'sd12;
    run_stream(STREAM_LEN);
    mux_loop   = '0;
  endtask

  task automatic test_sw_trigger(input post_t post);
    cts_t exp_ts;
    int   trg_cycles;
    int   wait_cnt;
    settle_quiet();
    acq_post  = post;
    trg_lvl   = sample_t'(SMP_MAX);
    acq_start = 1'b1;
    @(negedge adc_clk);
    acq_start = 1'b0;
    if (!acq_vld) flag_error("acq_vld_o stayed low after the start strobe");
    trg_swo = 1'b1;
    // Time stamp seen by the coming edge
    exp_ts = edge_cnt;
    @(negedge adc_clk);
    trg_swo  = 1'b0;
    wait_cnt = 0;
    while (!irq_trg && wait_cnt < 16) begin
      @(negedge adc_clk);
      wait_cnt++;
    end
    if (!irq_trg) begin
      flag_error("irq_trg_o did not rise after the software trigger");
    end else begin
      check_ts("trg_ts_o", trg_ts, exp_ts);
      // Triggered cycles up to the first idle one
      trg_cycles = 0;
      while (acq_vld && trg_cycles <= int'(post)) begin
        if (trg_cycles > 0 && irq_trg) flag_error("irq_trg_o high for more than one cycle");
        if (irq_stp) flag_error("irq_stp_o high during the triggered state");
        trg_cycles++;
        @(negedge adc_clk);
      end
      if (trg_cycles != int'(post))
        flag_error($sformatf("triggered state lasted %0d cycles, not %0d", trg_cycles, post));
      if (!irq_stp) flag_error("irq_stp_o missing in the first idle cycle");
      @(negedge adc_clk);
      if (irq_stp) flag_error("irq_stp_o high for more than one cycle");
    end
  endtask

  task automatic test_level_stop();
    sample_t ramp[16];
    int      cross_idx;
    int      trg_seen;
    int      stp_seen;
    int      trg_at;
    cts_t    exp_ts;
    settle_quiet();
    trg_lvl   = 14'sd5;
    acq_post  = post_t'(4);
    cross_idx = -1;
    trg_seen  = 0;
    stp_seen  = 0;
    trg_at    = -1;
    exp_ts    = '0;
    for (int j = 0; j < 16; j++) ramp[j] = sample_t'(-96 + 16 * j);
    // First step from below the level to at or above it
    for (int j = 1; j < 16; j++)
      if (cross_idx < 0 && ramp[j-1] < trg_lvl && ramp[j] >= trg_lvl) cross_idx = j;
    drive_adc_const(ramp[0]);
    acq_start = 1'b1;
    @(negedge adc_clk);
    acq_start = 1'b0;
    for (int j = 0; j < 28; j++) begin
      adc_dat[0] = sample_to_raw(ramp[j < 16 ? j : 15]);
      // Crossing sample reaches the FSM 3 cycles after its pins
      if (j == cross_idx + 3) exp_ts = edge_cnt;
      @(negedge adc_clk);
      if (irq_trg) begin
        trg_seen++;
        trg_at = j + 1;
      end
      if (irq_stp) stp_seen++;
    end
    if (trg_seen != 1) flag_error($sformatf("level trigger fired %0d times, not once", trg_seen));
    if (trg_at != cross_idx + 4) flag_error("level trigger at the wrong cycle");
    check_ts("trg_ts_o", trg_ts, exp_ts);
    if (stp_seen != 1) flag_error("irq_stp_o not seen once after the level trigger");
    // Arm again with the ramp held flat and stop early
    acq_start = 1'b1;
    @(negedge adc_clk);
    acq_start = 1'b0;
    @(negedge adc_clk);
    if (!acq_vld) flag_error("acq_vld_o low while armed");
    acq_stop = 1'b1;
    @(negedge adc_clk);
    acq_stop = 1'b0;
    if (acq_vld) flag_error("acq_vld_o still high after acq_stop_i");
    if (!irq_stp) flag_error("irq_stp_o missing after acq_stop_i");
    if (irq_trg) flag_error("irq_trg_o high although acquisition was stopped");
  endtask

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    top_rst   = 1'b1;
    adc_dat   = '0;
    gen_dat   = '0;
    mux_loop  = '0;
    adc_mul   = '0;
    adc_sum   = '0;
    dac_mul   = '0;
    dac_sum   = '0;
    acq_start = 1'b0;
    acq_stop  = 1'b0;
    trg_swo   = 1'b0;
    trg_lvl   = '0;
    acq_post  = post_t'(1);
    repeat (8) @(negedge adc_clk);
    top_rst = 1'b0;
    // Reset values
    check_code("dac_dat_o[0]", dac_dat[0], '0);
    check_code("dac_dat_o[1]", dac_dat[1], '0);
    check_ts("trg_ts_o", trg_ts, '0);
    if (irq_trg || irq_stp || acq_vld) flag_error("interrupt or valid high after reset");
    test_adc_unity();
    test_calib_sat();
    test_dac_format();
    test_loopback();
    test_sw_trigger(post_t'(5));
    test_sw_trigger(post_t'(1));
    test_level_stop();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : tb_top

`default_nettype wire

// File: tb.f
source/rp_cfg_pkg.sv
source/acq_pkg.sv
source/adc_frontend.sv
source/linear_calib.sv
source/dac_path.sv
source/acq_fsm.sv
source/acq_timer.sv
source/rp_acq_top.sv
tests/acq_assert.sv
tests/tb_top.sv

// File: Makefile
# Verilator build and run, pass is decided by the pass message in the output
TOP := tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -sv -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f tb.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
